// File: common/isaPkg.sv
`default_nettype none

package isaPkg;

  localparam int xlen = 32;
  localparam int regCount = 32;
  localparam int regAddrWidth = 5;

  localparam logic [6:0] opcodeRegOp = 7'b0110011;
  localparam logic [6:0] opcodeImmOp = 7'b0010011;
  localparam logic [6:0] opcodeLoad = 7'b0000011;
  localparam logic [6:0] opcodeStore = 7'b0100011;

  localparam logic [2:0] funct3Add = 3'b000;  // also sub
  localparam logic [2:0] funct3Sll = 3'b001;
  localparam logic [2:0] funct3Xor = 3'b100;
  localparam logic [2:0] funct3Shr = 3'b101;  // srl and sra
  localparam logic [2:0] funct3Or = 3'b110;
  localparam logic [2:0] funct3And = 3'b111;
  localparam logic [2:0] funct3Word = 3'b010;  // lw and sw

  localparam int altFunctBit = 30;  // picks sub or sra

  localparam logic [xlen-1:0] pcStep = 4;

  typedef logic [xlen-1:0] dataWord;
  typedef logic [regAddrWidth-1:0] regIndex;

  typedef struct packed {
    logic [6:0] funct7;
    regIndex rs2;
    regIndex rs1;
    logic [2:0] funct3;
    regIndex rd;
    logic [6:0] opcode;
  } rFormat;

  typedef struct packed {
    logic [11:0] imm12;
    regIndex rs1;
    logic [2:0] funct3;
    regIndex rd;
    logic [6:0] opcode;
  } iFormat;

  typedef struct packed {
    logic [6:0] immHigh;
    regIndex rs2;
    regIndex rs1;
    logic [2:0] funct3;
    logic [4:0] immLow;
    logic [6:0] opcode;
  } sFormat;

  // one instruction word, three decodings
  typedef union packed {
    rFormat rView;
    iFormat iView;
    sFormat sView;
  } instrWord;

endpackage

`default_nettype wire

// File: common/ctrlPkg.sv
`default_nettype none

package ctrlPkg;

  typedef enum logic [2:0] {
    stepFetch,
    stepMemWait,
    stepDecode,
    stepExec,
    stepAccess,
    stepWriteBack
  } stepState;

  typedef enum logic [3:0] {
    aluAdd,
    aluSub,
    aluSll,
    aluSrl,
    aluSra,
    aluXor,
    aluOr,
    aluAnd
  } aluOp;

  typedef enum logic {
    immI,
    immS
  } immKind;

  typedef struct packed {
    logic addrLoad;  // address reg <- pc
    logic pcAdvance;
    logic irLoad;
    logic resultLoad;
    logic useImm;
    immKind immSel;
    aluOp aluSel;
    logic dataAddr;  // result reg on memAddress
    logic memWrite;
    logic regWrite;
    logic writeFromMem;  // load data to rd
  } ctrlSignals;

endpackage

`default_nettype wire

// File: control/controlFsm.sv
`default_nettype none

module controlFsm (
  input logic Clock,
  input logic reset,
  input logic run,
  input isaPkg::instrWord instr,
  output ctrlPkg::ctrlSignals ctrl,
  output logic instrDone
);

  ctrlPkg::stepState state;
  ctrlPkg::stepState nextState;
  ctrlPkg::aluOp decodedOp;
  logic isRegOp;
  logic isImmOp;
  logic isLoad;
  logic isStore;
  logic altFunct;

  assign isRegOp = instr.rView.opcode == isaPkg::opcodeRegOp;
  assign isImmOp = instr.iView.opcode == isaPkg::opcodeImmOp;
  assign isLoad = (instr.iView.opcode == isaPkg::opcodeLoad) &&
                  (instr.iView.funct3 == isaPkg::funct3Word);
  assign isStore = (instr.rView.opcode == isaPkg::opcodeStore) &&
                   (instr.rView.funct3 == isaPkg::funct3Word);

  // bit 30, also the srai bit of imm12
  assign altFunct = instr.rView.funct7[isaPkg::altFunctBit - 25];

  always_comb begin
    decodedOp = ctrlPkg::aluAdd;  // loads and stores add too
    if (isRegOp || isImmOp) begin
      case (instr.rView.funct3)
        isaPkg::funct3Add: if (isRegOp && altFunct) decodedOp = ctrlPkg::aluSub;
        isaPkg::funct3Sll: decodedOp = ctrlPkg::aluSll;
        isaPkg::funct3Xor: decodedOp = ctrlPkg::aluXor;
        isaPkg::funct3Shr: decodedOp = altFunct ? ctrlPkg::aluSra : ctrlPkg::aluSrl;
        isaPkg::funct3Or: decodedOp = ctrlPkg::aluOr;
        isaPkg::funct3And: decodedOp = ctrlPkg::aluAnd;
        default: decodedOp = ctrlPkg::aluAdd;
      endcase
    end
  end

  always_ff @(posedge Clock) begin
    if (reset) begin
      state <= ctrlPkg::stepFetch;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    case (state)
      ctrlPkg::stepFetch: nextState = run ? ctrlPkg::stepMemWait : ctrlPkg::stepFetch;
      ctrlPkg::stepMemWait: nextState = ctrlPkg::stepDecode;
      ctrlPkg::stepDecode: nextState = ctrlPkg::stepExec;
      ctrlPkg::stepExec: nextState = ctrlPkg::stepAccess;
      ctrlPkg::stepAccess: nextState = ctrlPkg::stepWriteBack;
      default: nextState = ctrlPkg::stepFetch;  // after write-back
    endcase
  end

  always_comb begin
    ctrl = '0;
    ctrl.aluSel = decodedOp;
    ctrl.useImm = !isRegOp;
    ctrl.immSel = isStore ? ctrlPkg::immS : ctrlPkg::immI;
    case (state)
      ctrlPkg::stepFetch: begin
        ctrl.addrLoad = run;  // held in fetch until run
        ctrl.pcAdvance = run;
      end
      ctrlPkg::stepDecode: ctrl.irLoad = 1'b1;  // word is on readData now
      ctrlPkg::stepExec: ctrl.resultLoad = 1'b1;
      ctrlPkg::stepAccess: begin
        ctrl.dataAddr = isLoad || isStore;
        ctrl.memWrite = isStore;
      end
      ctrlPkg::stepWriteBack: begin
        ctrl.regWrite = isRegOp || isImmOp || isLoad;  // unknown opcode writes nothing
        ctrl.writeFromMem = isLoad;
      end
      default: ;
    endcase
  end

  assign instrDone = state == ctrlPkg::stepWriteBack;

endmodule

`default_nettype wire

// File: datapath/regFile.sv
`default_nettype none

module regFile (
  input logic Clock,
  input logic reset,
  input isaPkg::regIndex readIndexA,
  input isaPkg::regIndex readIndexB,
  output isaPkg::dataWord readDataA,
  output isaPkg::dataWord readDataB,
  input logic writeEnable,
  input isaPkg::regIndex writeIndex,
  input isaPkg::dataWord writeData
);

  isaPkg::dataWord regs [isaPkg::regCount];

  always_ff @(posedge Clock) begin
    if (reset) begin
      for (int i = 0; i < isaPkg::regCount; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEnable && (writeIndex != '0)) begin
      regs[writeIndex] <= writeData;  // x0 stays zero
    end
  end

  assign readDataA = regs[readIndexA];
  assign readDataB = regs[readIndexB];

endmodule

`default_nettype wire

// File: datapath/aluUnit.sv
`default_nettype none

module aluUnit (
  input isaPkg::dataWord operandA,
  input isaPkg::dataWord operandB,
  input ctrlPkg::aluOp aluSel,
  output isaPkg::dataWord result
);

  logic [4:0] shiftAmount;

  assign shiftAmount = operandB[4:0];  // rv32 shifts use 5 bits only

  always_comb begin
    case (aluSel)
      ctrlPkg::aluAdd: result = operandA + operandB;
      ctrlPkg::aluSub: result = operandA - operandB;
      ctrlPkg::aluSll: result = operandA << shiftAmount;
      ctrlPkg::aluSrl: result = operandA >> shiftAmount;
      ctrlPkg::aluSra: result = $signed(operandA) >>> shiftAmount;
      ctrlPkg::aluXor: result = operandA ^ operandB;
      ctrlPkg::aluOr: result = operandA | operandB;
      ctrlPkg::aluAnd: result = operandA & operandB;
      default: result = operandA + operandB;
    endcase
  end

endmodule

`default_nettype wire

// File: datapath/execPath.sv
`default_nettype none

module execPath (
  input logic Clock,
  input logic reset,
  input ctrlPkg::ctrlSignals ctrl,
  output isaPkg::instrWord instr,
  input isaPkg::dataWord readData,
  output isaPkg::dataWord memAddress,
  output isaPkg::dataWord writeData,
  output logic writeEnable
);

  isaPkg::dataWord pc;
  isaPkg::dataWord addrReg;
  isaPkg::dataWord resultReg;
  isaPkg::dataWord immValue;
  isaPkg::dataWord operandA;
  isaPkg::dataWord operandB;
  isaPkg::dataWord regDataB;
  isaPkg::dataWord aluResult;
  isaPkg::dataWord writeBackData;

  always_ff @(posedge Clock) begin
    if (reset) begin
      pc <= '0;
      addrReg <= '0;
      instr <= '0;
    end else begin
      if (ctrl.addrLoad) addrReg <= pc;
      if (ctrl.pcAdvance) pc <= pc + isaPkg::pcStep;
      if (ctrl.irLoad) instr <= readData;
    end
  end

  always_ff @(posedge Clock) begin
    if (ctrl.resultLoad) resultReg <= aluResult;
  end

  always_comb begin
    if (ctrl.immSel == ctrlPkg::immS) begin
      immValue = {{(isaPkg::xlen - 12){instr.sView.immHigh[6]}},
                  instr.sView.immHigh, instr.sView.immLow};
    end else begin
      immValue = {{(isaPkg::xlen - 12){instr.iView.imm12[11]}}, instr.iView.imm12};
    end
  end

  assign operandB = ctrl.useImm ? immValue : regDataB;
  assign memAddress = ctrl.dataAddr ? resultReg : addrReg;  // data access or fetch
  assign writeData = regDataB;  // rs2 for sw
  assign writeEnable = ctrl.memWrite;
  assign writeBackData = ctrl.writeFromMem ? readData : resultReg;

  regFile i_regs (
    .Clock(Clock),
    .reset(reset),
    .readIndexA(instr.rView.rs1),
    .readIndexB(instr.rView.rs2),
    .readDataA(operandA),
    .readDataB(regDataB),
    .writeEnable(ctrl.regWrite),
    .writeIndex(instr.rView.rd),
    .writeData(writeBackData)
  );

  aluUnit i_alu (
    .operandA(operandA),
    .operandB(operandB),
    .aluSel(ctrl.aluSel),
    .result(aluResult)
  );

endmodule

`default_nettype wire

// File: rtl/riscCore.sv
`default_nettype none

module riscCore (
  input logic Clock,
  input logic reset,
  input logic run,
  input isaPkg::dataWord readData,
  output isaPkg::dataWord memAddress,
  output isaPkg::dataWord writeData,
  output logic writeEnable,
  output logic instrDone
);

  ctrlPkg::ctrlSignals ctrl;
  isaPkg::instrWord instr;

  controlFsm i_control (
    .Clock(Clock),
    .reset(reset),
    .run(run),
    .instr(instr),
    .ctrl(ctrl),
    .instrDone(instrDone)
  );

  execPath i_datapath (
    .Clock(Clock),
    .reset(reset),
    .ctrl(ctrl),
    .instr(instr),
    .readData(readData),
    .memAddress(memAddress),
    .writeData(writeData),
    .writeEnable(writeEnable)
  );

endmodule

`default_nettype wire

// File: tb/isaModel.svh
`ifndef isaModelSvh
`define isaModelSvh

localparam int progLen = 64;
localparam int dataBase = 256;  // word of byte 0x400, held in x1

logic [31:0] lfsr = 32'hf127;
logic [31:0] progMem [progLen];
logic [31:0] modelRegs [32] = '{default: '0};
logic [31:0] modelMem [16];
logic [31:0] modelPc = '0;
logic [31:0] expFetch;
logic [31:0] expAddr;
logic [31:0] expData;
logic expLoad;
logic expStore;
int expTest;
int lastLoadRd = -1;
logic [2:0] f3Table [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

function automatic logic [31:0] randBits(input int count);
  logic [31:0] value = '0;
  for (int i = 0; i < count; i++) begin
    lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'hb4bcd35c : lfsr >> 1;  // one step per bit
    value = {value[30:0], lfsr[0]};
  end
  return value;
endfunction

function automatic logic [31:0] fillWord(input int index);
  return (32'(index) * 32'h9e3779b1) ^ (32'(index) << 20);
endfunction

function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic alt,
                                         input logic [31:0] a, input logic [31:0] b);
  case (f3)
    3'd0: return alt ? a - b : a + b;
    3'd1: return a << b[4:0];
    3'd4: return a ^ b;
    3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'd6: return a | b;
    default: return a & b;
  endcase
endfunction

function automatic logic [31:0] storeWord(input logic [4:0] rs2);
  logic [11:0] offset = {6'd0, 4'(randBits(4)), 2'd0};
  return {offset[11:5], rs2, 5'd1, isaPkg::funct3Word, offset[4:0], isaPkg::opcodeStore};
endfunction

task automatic buildProgram();
  logic [2:0] kind;
  logic [2:0] f3;
  logic [4:0] rd;
  logic [4:0] src;
  logic [11:0] imm;
  logic alt;
  int n = 1;
  progMem[0] = {12'h400, 5'd0, 3'd0, 5'd1, isaPkg::opcodeImmOp};  // addi x1, x0, 0x400
  while (n < progLen) begin
    kind = 3'(randBits(3));
    f3 = f3Table[randBits(3) % 6];
    rd = 5'(randBits(5));
    if (rd == 5'd1) rd = 5'd0;  // x1 stays the data base
    src = 5'(randBits(5));
    imm = 12'(randBits(12));
    alt = (randBits(1) != 0) && (f3 == 3'd0 || f3 == 3'd5);
    if (n == progLen - 2) begin
      progMem[n] = {imm, src, 3'd0, 5'd0, isaPkg::opcodeImmOp};  // write to x0
    end else if (n == progLen - 1) begin
      progMem[n] = storeWord(5'd0);
    end else if (kind < 3 && f3[1:0] == 2'b01) begin
      progMem[n] = {1'b0, alt, 5'd0, imm[4:0], src, f3, rd, isaPkg::opcodeImmOp};
    end else if (kind < 3) begin
      progMem[n] = {imm, src, f3, rd, isaPkg::opcodeImmOp};
    end else if (kind < 5) begin
      progMem[n] = {1'b0, alt, 5'd0, imm[4:0], src, f3, rd, isaPkg::opcodeRegOp};
    end else if (kind == 5 && n < progLen - 3) begin
      progMem[n] = {6'd0, imm[3:0], 2'd0, 5'd1, isaPkg::funct3Word, rd, isaPkg::opcodeLoad};
      n++;
      progMem[n] = storeWord(rd);  // shows the loaded word
    end else begin
      progMem[n] = storeWord(src);
    end
    n++;
  end
endtask

task automatic execModel(input logic [31:0] word);
  logic [31:0] a = modelRegs[word[19:15]];
  logic [31:0] b = modelRegs[word[24:20]];
  logic [31:0] immI = {{20{word[31]}}, word[31:20]};
  logic [31:0] result = '0;
  logic writes = 1'b1;
  expFetch = modelPc;
  expLoad = word[6:0] == isaPkg::opcodeLoad;
  expStore = word[6:0] == isaPkg::opcodeStore;
  expAddr = a + (expStore ? {{20{word[31]}}, word[31:25], word[11:7]} : immI);
  expData = b;
  expTest = word[24:20] == 5'd0 ? 5 : (int'(word[24:20]) == lastLoadRd ? 4 : 3);
  case (word[6:0])
    isaPkg::opcodeRegOp: result = aluModel(word[14:12], word[30], a, b);
    isaPkg::opcodeImmOp: result = aluModel(word[14:12], word[30] && word[14:12] == 3'd5, a, immI);
    isaPkg::opcodeLoad: result = modelMem[expAddr[5:2]];
    default: writes = 1'b0;
  endcase
  if (expStore) modelMem[expAddr[5:2]] = b;
  if (writes && word[11:7] != 5'd0) modelRegs[word[11:7]] = result;
  lastLoadRd = expLoad ? int'(word[11:7]) : -1;
  modelPc += 4;
endtask

`endif

// File: tb/coreTb.sv
`default_nettype none

module coreTb;
  timeunit 1ns;
  timeprecision 100ps;

  logic Clock = 1'b0;
  logic reset = 1'b1;
  logic run = 1'b0;
  isaPkg::dataWord readData = '0;
  isaPkg::dataWord memAddress;
  isaPkg::dataWord writeData;
  logic writeEnable;
  logic instrDone;
  logic [31:0] tbMem [512];
  int cycleCount = 0;
  int checkCount = 0;
  int testErrors [7] = '{default: 0};

  `include "isaModel.svh"

  localparam int cycleLimit = 6 * progLen * 2 + 100;

  riscCore i_dut (
    .Clock(Clock),
    .reset(reset),
    .run(run),
    .readData(readData),
    .memAddress(memAddress),
    .writeData(writeData),
    .writeEnable(writeEnable),
    .instrDone(instrDone)
  );

  always #5 Clock = ~Clock;

  always @(posedge Clock) begin
    if (reset) begin
      for (int i = 0; i < 512; i++) begin
        tbMem[i] <= i < progLen ? progMem[i] : fillWord(i);
      end
    end else if (writeEnable) begin
      tbMem[memAddress[10:2]] <= writeData;
    end
    readData <= tbMem[memAddress[10:2]];  // answered in the next cycle
  end

  initial begin
    wait (cycleCount > cycleLimit);
    $display("timeout: core stopped finishing instructions after %0d cycles", cycleCount);
    $display("=== FAIL ===");
    $finish;
  end

  task automatic stepCycle();
    @(negedge Clock);
    cycleCount++;
  endtask

  task automatic checkValue(input int testId, input logic [31:0] got,
                            input logic [31:0] expected, input string what);
    checkCount++;
    if (got !== expected) begin
      testErrors[testId]++;
      $display("[FAIL] %0d ns: %s is %h, expected %h", $time, what, got, expected);
    end
  endtask

  task automatic reportTest(input int testId, input string name);
    $display("test %0d, %s: %0d errors", testId, name, testErrors[testId]);
  endtask

  task automatic runInstruction(input logic last);
    int cyc = 0;
    execModel(progMem[modelPc[7:2]]);
    do begin
      stepCycle();
      cyc++;
      if (cyc == 1) checkValue(2, memAddress, expFetch, "fetch address");
      if (cyc == 4 && (expLoad || expStore)) begin
        checkValue(expLoad ? 4 : 3, memAddress, expAddr, "data address");
      end
      if (cyc == 4 && expStore) checkValue(expTest, writeData, expData, "store data");
      checkValue(3, 32'(writeEnable), 32'(cyc == 4 && expStore), "writeEnable");
    end while (!instrDone);
    checkValue(2, cyc, 5, "cycles from fetch to instrDone");  // sixth cycle, fetch included
    if (last) begin
      run = 1'b0;
    end else begin
      stepCycle();  // next fetch
    end
  endtask

  initial begin
    int errorTotal;
    errorTotal = 0;
    buildProgram();
    for (int k = 0; k < 16; k++) begin
      modelMem[k] = fillWord(dataBase + k);
    end
    repeat (5) @(negedge Clock);
    reset = 1'b0;
    repeat (6 + int'(randBits(5))) begin
      stepCycle();
      checkValue(1, memAddress, '0, "idle memAddress");
      checkValue(1, 32'(instrDone), '0, "idle instrDone");
      checkValue(1, 32'(writeEnable), '0, "idle writeEnable");
    end
    reportTest(1, "reset and idle with run low");
    run = 1'b1;
    for (int n = 0; n < progLen; n++) begin
      runInstruction(n == progLen - 1);
    end
    reportTest(2, "fetch address and instrDone timing");
    reportTest(3, "store address and data after ALU sequences");
    reportTest(4, "load address and loaded word");
    reportTest(5, "writes to x0 discarded");
    for (int k = 0; k < 16; k++) begin
      checkValue(6, tbMem[dataBase + k], modelMem[k], "data region word");
    end
    reportTest(6, "data region against model memory");
    for (int t = 1; t < 7; t++) begin
      errorTotal += testErrors[t];
    end
    $display("checks %0d, errors %0d", checkCount, errorTotal);
    if (errorTotal == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+tb
common/isaPkg.sv
common/ctrlPkg.sv
control/controlFsm.sv
datapath/regFile.sv
datapath/aluUnit.sv
datapath/execPath.sv
rtl/riscCore.sv
tb/coreTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= coreTb
FILELIST ?= files.f
OBJDIR ?= obj_dir
VFLAGS ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "=== PASS ==="

clean:
	rm -rf $(OBJDIR)
